// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_xfcp_axil
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass or fail taken from $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: list.f
logic/xfcp_pkg.sv
logic/stream_skid_buffer.sv
logic/axil_master_port.sv
logic/xfcp_frame_ctrl.sv
logic/xfcp_axil_top.sv
testbench/xfcp_axil_properties.sv
testbench/tb_xfcp_axil.sv

// File: logic/axil_master_port.sv
// AXI-lite master for one outstanding single-beat request, completion signalled by done
module axil_master_port (
    input  logic                        clk,
    input  logic                        rst,
    input  xfcp_pkg::bus_req_t          req,
    input  logic                        req_valid,
    output xfcp_pkg::axil_aw_t          aw,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output xfcp_pkg::axil_w_t           w,
    output logic                        w_valid,
    input  logic                        w_ready,
    input  logic                        b_valid,
    output logic                        b_ready,
    output xfcp_pkg::axil_ar_t          ar,
    output logic                        ar_valid,
    input  logic                        ar_ready,
    input  xfcp_pkg::axil_r_t           r,
    input  logic                        r_valid,
    output logic                        r_ready,
    output logic                        done,
    output logic [xfcp_pkg::data_w-1:0] rdata
);
    xfcp_pkg::bus_req_t req_hold;
    logic               b_fire;
    logic               r_fire;

    assign b_fire = b_valid && b_ready;
    assign r_fire = r_valid && r_ready;

    assign aw = '{addr: req_hold.addr, prot: xfcp_pkg::axil_prot};
    assign ar = '{addr: req_hold.addr, prot: xfcp_pkg::axil_prot};
    assign w = '{data: req_hold.data, strb: req_hold.strb};

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            b_ready <= 1'b0;
            ar_valid <= 1'b0;
            r_ready <= 1'b0;
            done <= 1'b0;
        end else begin
            if (req_valid) begin
                // raise only the channels of this request type
                aw_valid <= req.write;
                w_valid <= req.write;
                b_ready <= req.write;
                ar_valid <= !req.write;
                r_ready <= !req.write;
            end else begin
                // each channel drops on its own handshake
                aw_valid <= aw_valid && !aw_ready;
                w_valid <= w_valid && !w_ready;
                ar_valid <= ar_valid && !ar_ready;
                b_ready <= b_ready && !b_valid;
                r_ready <= r_ready && !r_valid;
            end
            done <= b_fire || r_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_hold <= req;
        end
        if (r_fire) begin
            rdata <= r.data;
        end
    end

endmodule

// File: logic/stream_skid_buffer.sv
// registered output stage for the upstream byte stream, holds up to two beats under back-pressure
module stream_skid_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  xfcp_pkg::stream_beat_t int_beat,
    input  logic                   int_valid,
    output logic                   int_ready,
    output logic                   int_ready_early,
    output xfcp_pkg::stream_beat_t us_beat,
    output logic                   us_valid,
    input  logic                   us_ready
);
    xfcp_pkg::stream_beat_t temp_beat;
    logic                   temp_valid;
    logic                   us_valid_next;
    logic                   temp_valid_next;
    logic                   load_out;
    logic                   load_temp;
    logic                   temp_to_out;

    // ready next cycle if output drains or temp stays empty
    assign int_ready_early = us_ready || (!temp_valid && (!us_valid || !int_valid));

    always_comb begin
        us_valid_next = us_valid;
        temp_valid_next = temp_valid;
        load_out = 1'b0;
        load_temp = 1'b0;
        temp_to_out = 1'b0;

        if (int_ready) begin
            if (us_ready || !us_valid) begin
                us_valid_next = int_valid;
                load_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = int_valid;
                load_temp = 1'b1;
            end
        end else if (us_ready) begin
            us_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            us_valid <= 1'b0;
            temp_valid <= 1'b0;
            int_ready <= 1'b0;
        end else begin
            us_valid <= us_valid_next;
            temp_valid <= temp_valid_next;
            int_ready <= int_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            us_beat <= int_beat;
        end else if (temp_to_out) begin
            us_beat <= temp_beat;
        end
        if (load_temp) begin
            temp_beat <= int_beat;
        end
    end

endmodule

// File: logic/xfcp_axil_top.sv
// bridge top level, instantiate with COUNT_W to match the packet count field width
module xfcp_axil_top #(
    parameter int COUNT_W = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    // request packets in
    input  xfcp_pkg::stream_beat_t ds_beat,
    input  logic                   ds_valid,
    output logic                   ds_ready,
    // response packets out
    output xfcp_pkg::stream_beat_t us_beat,
    output logic                   us_valid,
    input  logic                   us_ready,
    // axi-lite master
    output xfcp_pkg::axil_aw_t     aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output xfcp_pkg::axil_w_t      w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   b_valid,
    output logic                   b_ready,
    output xfcp_pkg::axil_ar_t     ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  xfcp_pkg::axil_r_t      r,
    input  logic                   r_valid,
    output logic                   r_ready
);
    xfcp_pkg::stream_beat_t      int_beat;
    logic                        int_valid;
    logic                        int_ready;
    logic                        int_ready_early;
    xfcp_pkg::bus_req_t          req;
    logic                        req_valid;
    logic                        done;
    logic [xfcp_pkg::data_w-1:0] rdata;

    xfcp_frame_ctrl #(.COUNT_W(COUNT_W)) u_frame_ctrl (.*);

    axil_master_port u_master_port (.*);

    stream_skid_buffer u_skid_buffer (.*);

endmodule

// File: logic/xfcp_frame_ctrl.sv
// packet FSM: parses request headers, drives bus requests and builds response packets
module xfcp_frame_ctrl #(
    parameter int COUNT_W = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  xfcp_pkg::stream_beat_t      ds_beat,
    input  logic                        ds_valid,
    output logic                        ds_ready,
    output xfcp_pkg::stream_beat_t      int_beat,
    output logic                        int_valid,
    input  logic                        int_ready,
    input  logic                        int_ready_early,
    output xfcp_pkg::bus_req_t          req,
    output logic                        req_valid,
    input  logic                        done,
    input  logic [xfcp_pkg::data_w-1:0] rdata
);
    localparam int count_bytes = (COUNT_W + 7) / 8;
    localparam int hdr_bytes = count_bytes + xfcp_pkg::addr_bytes;
    localparam int aw = xfcp_pkg::addr_w;

    typedef enum logic [2:0] {
        st_idle, st_type, st_fields, st_write_data,
        st_write_wait, st_read_wait, st_read_send, st_wait_last
    } state_t;

    state_t                      state, state_next;
    logic [COUNT_W-1:0]          ptr, ptr_next;
    logic [2:0]                  idx, idx_next;
    logic [1:0]                  lane, lane_next;
    logic                        write, write_next;
    logic [aw-1:0]               addr, addr_next;
    logic [xfcp_pkg::data_w-1:0] data, data_next;
    logic [xfcp_pkg::strb_w-1:0] strb, strb_next;
    logic                        ds_ready_next;
    logic                        req_valid_next;
    logic                        last_seen;
    logic                        ds_fire;
    logic                        drain_ready;

    assign ds_fire = ds_valid && ds_ready;
    // keep pulling padding until the packet end shows up
    assign drain_ready = !(last_seen || (ds_valid && ds_beat.last));

    assign req = '{write: write, addr: {addr[aw-1:2], 2'b00}, data: data, strb: strb};

    always_comb begin
        state_next = state;
        ptr_next = ptr;
        idx_next = idx;
        lane_next = lane;
        write_next = write;
        addr_next = addr;
        data_next = data;
        strb_next = strb;
        ds_ready_next = int_ready_early;
        req_valid_next = 1'b0;
        int_beat = '0;
        int_valid = 1'b0;

        case (state)
            st_idle: begin
                // a lone last beat or a wrong start byte is dropped
                if (ds_fire && !ds_beat.last) begin
                    if (ds_beat.data == xfcp_pkg::start_tag) begin
                        state_next = st_type;
                    end else begin
                        ds_ready_next = 1'b1;
                        state_next = st_wait_last;
                    end
                end
            end
            st_type: begin
                if (ds_fire) begin
                    int_valid = 1'b1;
                    idx_next = 3'(hdr_bytes - 1);
                    if (ds_beat.data == xfcp_pkg::read_req && !ds_beat.last) begin
                        int_beat.data = xfcp_pkg::read_resp;
                        write_next = 1'b0;
                        state_next = st_fields;
                    end else if (ds_beat.data == xfcp_pkg::write_req && !ds_beat.last) begin
                        int_beat.data = xfcp_pkg::write_resp;
                        write_next = 1'b1;
                        state_next = st_fields;
                    end else begin
                        // unknown type, single error beat
                        int_beat.last = 1'b1;
                        int_beat.user = 1'b1;
                        if (ds_beat.last) begin
                            state_next = st_idle;
                        end else begin
                            ds_ready_next = 1'b1;
                            state_next = st_wait_last;
                        end
                    end
                end
            end
            st_fields: begin
                if (ds_fire) begin
                    int_valid = 1'b1;
                    int_beat.data = ds_beat.data;
                    // count first, then address, both msb first
                    if (idx >= 3'(xfcp_pkg::addr_bytes)) begin
                        ptr_next = COUNT_W'({ptr, ds_beat.data});
                    end else begin
                        addr_next = {addr[aw-9:0], ds_beat.data};
                    end
                    idx_next = idx - 3'd1;
                    lane_next = addr_next[1:0];
                    data_next = '0;
                    strb_next = '0;
                    if (ds_beat.last && (idx != 3'd0 || write || ptr_next == '0)) begin
                        // packet cut short, only a read of some bytes may end at the header
                        int_beat.last = 1'b1;
                        int_beat.user = 1'b1;
                        state_next = st_idle;
                    end else if (idx == 3'd0) begin
                        if (ptr_next == '0 || write) begin
                            int_beat.last = 1'b1;
                            ds_ready_next = 1'b1;
                            state_next = (ptr_next == '0) ? st_wait_last : st_write_data;
                        end else begin
                            ds_ready_next = drain_ready;
                            req_valid_next = 1'b1;
                            state_next = st_read_wait;
                        end
                    end
                end
            end
            st_write_data: begin
                ds_ready_next = 1'b1;
                if (ds_fire) begin
                    data_next[8*lane +: 8] = ds_beat.data;
                    strb_next[lane] = 1'b1;
                    lane_next = lane + 2'd1;
                    ptr_next = ptr - 1'b1;
                    // flush the word when full, at block end or at early packet end
                    if (lane == 2'd3 || ptr == COUNT_W'(1) || ds_beat.last) begin
                        ds_ready_next = 1'b0;
                        req_valid_next = 1'b1;
                        state_next = st_write_wait;
                        if (ds_beat.last) begin
                            ptr_next = '0;
                        end
                    end
                end
            end
            st_write_wait: begin
                ds_ready_next = 1'b0;
                if (done) begin
                    data_next = '0;
                    strb_next = '0;
                    addr_next = addr + aw'(4);
                    if (ptr != '0) begin
                        ds_ready_next = 1'b1;
                        state_next = st_write_data;
                    end else if (last_seen) begin
                        ds_ready_next = int_ready_early;
                        state_next = st_idle;
                    end else begin
                        ds_ready_next = 1'b1;
                        state_next = st_wait_last;
                    end
                end
            end
            st_read_wait: begin
                ds_ready_next = drain_ready;
                if (done) begin
                    data_next = rdata;
                    addr_next = addr + aw'(4);
                    state_next = st_read_send;
                end
            end
            st_read_send: begin
                ds_ready_next = drain_ready;
                if (int_ready) begin
                    int_valid = 1'b1;
                    int_beat.data = data[8*lane +: 8];
                    lane_next = lane + 2'd1;
                    ptr_next = ptr - 1'b1;
                    if (ptr == COUNT_W'(1)) begin
                        int_beat.last = 1'b1;
                        if (drain_ready) begin
                            ds_ready_next = 1'b1;
                            state_next = st_wait_last;
                        end else begin
                            ds_ready_next = int_ready_early;
                            state_next = st_idle;
                        end
                    end else if (lane == 2'd3) begin
                        // lane wrap, fetch the next word
                        req_valid_next = 1'b1;
                        state_next = st_read_wait;
                    end
                end
            end
            st_wait_last: begin
                ds_ready_next = 1'b1;
                if (ds_fire && ds_beat.last) begin
                    ds_ready_next = int_ready_early;
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            ds_ready <= 1'b0;
            req_valid <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            state <= state_next;
            ds_ready <= ds_ready_next;
            req_valid <= req_valid_next;
            if (ds_fire) begin
                last_seen <= ds_beat.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        ptr <= ptr_next;
        idx <= idx_next;
        lane <= lane_next;
        write <= write_next;
        addr <= addr_next;
        data <= data_next;
        strb <= strb_next;
    end

endmodule

// File: logic/xfcp_pkg.sv
// shared constants, packet codes and packed beat and bus channel types for the xfcp bridge
package xfcp_pkg;

    // packet framing codes
    localparam logic [7:0] start_tag  = 8'hff;
    localparam logic [7:0] read_req   = 8'h10;
    localparam logic [7:0] read_resp  = 8'h11;
    localparam logic [7:0] write_req  = 8'h12;
    localparam logic [7:0] write_resp = 8'h13;

    // bus geometry, fixed at one 32 bit word
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int strb_w     = data_w / 8;
    localparam int addr_bytes = addr_w / 8;

    // unprivileged, non-secure, data access
    localparam logic [2:0] axil_prot = 3'd2;

    // one byte of the packet stream, user marks an error
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } stream_beat_t;

    // single word request from frame controller to bus port
    typedef struct packed {
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } bus_req_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axil_aw_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axil_ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
    } axil_r_t;

endpackage

// File: testbench/tb_xfcp_axil.sv
// testbench for the xfcp AXI-lite bridge, top module tb_xfcp_axil, compiled from list.f
module tb_xfcp_axil;
    localparam int count_w = 16;
    // six packets at about a hundred cycles each under random stalls, with wide margin
    localparam int timeout_cycles = 4000;

    logic                   clk = 1'b0;
    logic                   rst;
    xfcp_pkg::stream_beat_t ds_beat;
    logic                   ds_valid;
    logic                   ds_ready;
    xfcp_pkg::stream_beat_t us_beat;
    logic                   us_valid;
    logic                   us_ready;
    xfcp_pkg::axil_aw_t     aw;
    logic                   aw_valid;
    logic                   aw_ready;
    xfcp_pkg::axil_w_t      w;
    logic                   w_valid;
    logic                   w_ready;
    logic                   b_valid;
    logic                   b_ready;
    xfcp_pkg::axil_ar_t     ar;
    logic                   ar_valid;
    logic                   ar_ready;
    xfcp_pkg::axil_r_t      r;
    logic                   r_valid;
    logic                   r_ready;

    xfcp_pkg::stream_beat_t exp_q[$];
    logic [35:0]            wr_exp_q[$];
    logic [31:0]            rd_exp_q[$];
    logic [7:0]             pkt_q[$];
    logic [7:0]             shadow[256];
    logic [31:0]            mem[64];
    xfcp_pkg::stream_beat_t exp_beat;
    logic [35:0]            exp_wr;
    logic [31:0]            exp_rd;
    logic [31:0]            wr_addr;
    xfcp_pkg::axil_w_t      wr_beat;
    logic [31:0]            rd_word;
    logic                   have_aw = 1'b0;
    logic                   have_w = 1'b0;
    logic                   b_pend = 1'b0;
    logic                   r_pend = 1'b0;
    string                  test_name = "reset";
    int                     errors = 0;
    int                     cycles = 0;

    xfcp_axil_top #(.COUNT_W(count_w)) DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout in %s after %0d cycles, %0d bench errors, %0d property failures",
                     test_name, cycles, errors, DUT.u_props.fail_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // upstream monitor against the expected response queue
    always @(posedge clk) begin
        if (!rst && us_valid && us_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: upstream beat %h arrived with no response expected",
                         test_name, us_beat);
            end else begin
                exp_beat = exp_q.pop_front();
                assert (us_beat.last == exp_beat.last && us_beat.user == exp_beat.user
                        && (exp_beat.user || us_beat.data == exp_beat.data))
                else begin
                    errors++;
                    $display("Error: %s upstream beat expected %h actual %h",
                             test_name, exp_beat, us_beat);
                end
            end
        end
    end

    // AXI-lite memory model with random ready and response delays
    always @(posedge clk) begin
        if (b_valid && b_ready) begin
            b_pend = 1'b0;
        end
        if (r_valid && r_ready) begin
            r_pend = 1'b0;
        end
        if (aw_valid && aw_ready) begin
            wr_addr = aw.addr;
            have_aw = 1'b1;
            assert (aw.prot == xfcp_pkg::axil_prot)
            else begin
                errors++;
                $display("Error: %s write prot expected %h actual %h",
                         test_name, xfcp_pkg::axil_prot, aw.prot);
            end
        end
        if (w_valid && w_ready) begin
            wr_beat = w;
            have_w = 1'b1;
        end
        if (have_aw && have_w) begin
            if (wr_exp_q.size() == 0) begin
                errors++;
                $display("%s: unexpected bus write at %h", test_name, wr_addr);
            end else begin
                exp_wr = wr_exp_q.pop_front();
                assert ({wr_addr, wr_beat.strb} == exp_wr)
                else begin
                    errors++;
                    $display("Error: %s bus write addr/strb expected %h actual %h",
                             test_name, exp_wr, {wr_addr, wr_beat.strb});
                end
            end
            for (int l = 0; l < 4; l++) begin
                if (wr_beat.strb[l]) begin
                    mem[wr_addr[7:2]][8*l +: 8] = wr_beat.data[8*l +: 8];
                end
            end
            have_aw = 1'b0;
            have_w = 1'b0;
            b_pend = 1'b1;
        end
        if (ar_valid && ar_ready) begin
            assert (ar.prot == xfcp_pkg::axil_prot)
            else begin
                errors++;
                $display("Error: %s read prot expected %h actual %h",
                         test_name, xfcp_pkg::axil_prot, ar.prot);
            end
            if (rd_exp_q.size() == 0) begin
                errors++;
                $display("%s: unexpected bus read at %h", test_name, ar.addr);
            end else begin
                exp_rd = rd_exp_q.pop_front();
                assert (ar.addr == exp_rd)
                else begin
                    errors++;
                    $display("Error: %s bus read address expected %h actual %h",
                             test_name, exp_rd, ar.addr);
                end
            end
            rd_word = mem[ar.addr[7:2]];
            r_pend = 1'b1;
        end
        #2;
        aw_ready = ($urandom % 2) == 0;
        w_ready = ($urandom % 2) == 0;
        ar_ready = ($urandom % 2) == 0;
        us_ready = ($urandom % 4) != 0;
        if (!b_pend) begin
            b_valid = 1'b0;
        end else if (!b_valid) begin
            b_valid = ($urandom % 2) == 0;
        end
        if (!r_pend) begin
            r_valid = 1'b0;
        end else if (!r_valid) begin
            r = '{data: rd_word, resp: 2'b00};
            r_valid = ($urandom % 2) == 0;
        end
    end

    function automatic void expect_beat(input logic [7:0] data, input logic last,
                                        input logic user);
        exp_q.push_back('{data: data, last: last, user: user});
    endfunction

    // called and returns 2 units after a rising edge
    task automatic send_packet();
        for (int k = 0; k < pkt_q.size(); k++) begin
            ds_beat = '{data: pkt_q[k], last: k == pkt_q.size() - 1, user: 1'b0};
            ds_valid = 1'b1;
            @(posedge clk);
            while (!ds_ready) begin
                @(posedge clk);
            end
            #2;
        end
        ds_valid = 1'b0;
        while (exp_q.size() != 0 || wr_exp_q.size() != 0 || rd_exp_q.size() != 0) begin
            @(posedge clk);
        end
        // room for a stray beat to show up before the next packet
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic run_request(input string name, input logic wr, input int count,
                               input logic [31:0] addr);
        logic [7:0]  b;
        logic [3:0]  strb;
        logic [31:0] wa;
        int          a;
        test_name = name;
        strb = '0;
        pkt_q = '{xfcp_pkg::start_tag, wr ? xfcp_pkg::write_req : xfcp_pkg::read_req};
        expect_beat(wr ? xfcp_pkg::write_resp : xfcp_pkg::read_resp, 1'b0, 1'b0);
        // count then address, msb first, echoed back
        for (int i = (count_w + 7) / 8 - 1; i >= 0; i--) begin
            b = 8'(count >> (8 * i));
            pkt_q.push_back(b);
            expect_beat(b, 1'b0, 1'b0);
        end
        for (int i = 3; i >= 0; i--) begin
            b = addr[8*i +: 8];
            pkt_q.push_back(b);
            expect_beat(b, wr && i == 0, 1'b0);
        end
        for (int i = 0; i < count; i++) begin
            a = (int'(addr[7:0]) + i) % 256;
            wa = (addr + 32'(i)) & ~32'h3;
            if (wr) begin
                b = 8'($urandom);
                shadow[a] = b;
                pkt_q.push_back(b);
            end else begin
                expect_beat(shadow[a], i == count - 1, 1'b0);
            end
            strb[a % 4] = 1'b1;
            // one bus word ends at a lane wrap or at the block end
            if (a % 4 == 3 || i == count - 1) begin
                if (wr) begin
                    wr_exp_q.push_back({wa, strb});
                end else begin
                    rd_exp_q.push_back(wa);
                end
                strb = '0;
            end
        end
        send_packet();
    endtask

    initial begin
        void'($urandom(32'ha605));
        // each memory byte starts out holding its own address
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 8'(i);
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8'(4 * i + 3), 8'(4 * i + 2), 8'(4 * i + 1), 8'(4 * i)};
        end
        rst = 1'b1;
        ds_beat = '0;
        ds_valid = 1'b0;
        us_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        ar_ready = 1'b0;
        r = '0;
        r_valid = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        run_request("write_single", 1'b1, 4, 32'h10);
        run_request("read_single", 1'b0, 4, 32'h10);
        test_name = "bad_start";
        pkt_q = '{8'h55, xfcp_pkg::read_req, 8'h00, 8'h04};
        send_packet();
        run_request("write_unaligned", 1'b1, 6, 32'h21);
        test_name = "bad_type";
        pkt_q = '{xfcp_pkg::start_tag, 8'h33, 8'h00, 8'h04};
        expect_beat(8'h00, 1'b1, 1'b1);
        send_packet();
        run_request("read_unaligned", 1'b0, 6, 32'h21);

        $display("closing report: %0d bench errors, %0d property failures in %0d cycles",
                 errors, DUT.u_props.fail_count, cycles);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: testbench/xfcp_axil_properties.sv
// bound port assertions for the xfcp bridge, attached to every xfcp_axil_top by the bind below
module xfcp_axil_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   ds_valid,
    input xfcp_pkg::stream_beat_t us_beat,
    input logic                   us_valid,
    input logic                   us_ready,
    input xfcp_pkg::axil_aw_t     aw,
    input logic                   aw_valid,
    input logic                   aw_ready,
    input xfcp_pkg::axil_w_t      w,
    input logic                   w_valid,
    input logic                   w_ready,
    input xfcp_pkg::axil_ar_t     ar,
    input logic                   ar_valid,
    input logic                   ar_ready,
    input logic                   b_ready,
    input logic                   r_ready
);
    int   fail_count = 0;
    logic seen_input;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_input <= 1'b0;
        end else if (ds_valid) begin
            seen_input <= 1'b1;
        end
    end

    // nothing leaves the bridge before the first request byte
    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_input |-> !(us_valid || aw_valid || w_valid || ar_valid || b_ready || r_ready))
        else begin
            fail_count++;
            $error("bridge outputs active before the first request");
        end

    us_hold: assert property (@(posedge clk) disable iff (rst)
        us_valid && !us_ready |=> us_valid && $stable(us_beat))
        else begin
            fail_count++;
            $error("upstream beat changed or dropped while stalled");
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            fail_count++;
            $error("write address changed or dropped before its handshake");
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin
            fail_count++;
            $error("write data changed or dropped before its handshake");
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            fail_count++;
            $error("read address changed or dropped before its handshake");
        end

    // an error beat always closes its response
    error_is_last: assert property (@(posedge clk) disable iff (rst)
        us_valid && us_beat.user |-> us_beat.last)
        else begin
            fail_count++;
            $error("upstream error beat without last");
        end

endmodule

bind xfcp_axil_top xfcp_axil_properties u_props (.*);
